/* hw/dlxPkg.sv */
package dlxPkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] func;
	} rFmtS;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs1;
		logic [4:0]  rd;     // store data source for stores
		logic [15:0] imm16;
	} iFmtS;

	typedef union packed {
		rFmtS r;
		iFmtS i;
	} instrU;

	localparam logic [31:0] NOP_WORD = 32'h0000_0015;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDUI = 6'b001001;
	localparam logic [5:0] OP_SUBI  = 6'b001010;
	localparam logic [5:0] OP_SUBUI = 6'b001011;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LHI   = 6'b001111;
	localparam logic [5:0] OP_SLLI  = 6'b010100;
	localparam logic [5:0] OP_SRLI  = 6'b010110;
	localparam logic [5:0] OP_SRAI  = 6'b010111;
	localparam logic [5:0] OP_SEQI  = 6'b011000;
	localparam logic [5:0] OP_SNEI  = 6'b011001;
	localparam logic [5:0] OP_SLTI  = 6'b011010;
	localparam logic [5:0] OP_SGTI  = 6'b011011;
	localparam logic [5:0] OP_SLEI  = 6'b011100;
	localparam logic [5:0] OP_SGEI  = 6'b011101;
	localparam logic [5:0] OP_LB    = 6'b100000;
	localparam logic [5:0] OP_LH    = 6'b100001;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_LBU   = 6'b100100;
	localparam logic [5:0] OP_LHU   = 6'b100101;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SH    = 6'b101001;
	localparam logic [5:0] OP_SW    = 6'b101011;

	localparam logic [5:0] FN_SLL  = 6'b000100;
	localparam logic [5:0] FN_SRL  = 6'b000110;
	localparam logic [5:0] FN_SRA  = 6'b000111;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SEQ  = 6'b101000;
	localparam logic [5:0] FN_SNE  = 6'b101001;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SGT  = 6'b101011;
	localparam logic [5:0] FN_SLE  = 6'b101100;
	localparam logic [5:0] FN_SGE  = 6'b101101;

	localparam logic [1:0] MSZ_BYTE = 2'd0;
	localparam logic [1:0] MSZ_HALF = 2'd1;
	localparam logic [1:0] MSZ_WORD = 2'd2;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SEQ, ALU_SNE, ALU_SLT, ALU_SGT, ALU_SLE, ALU_SGE, ALU_LHI
	} aluOpE;

	typedef enum logic [1:0] {
		FWD_REG, FWD_EXMEM, FWD_MEMWB
	} fwdSelE;

	typedef struct packed {
		logic [31:0] rs1Val;
		logic [31:0] rs2Val;
		logic [31:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		aluOpE       aluOp;
		logic        useImm;
		logic        isLoad;
		logic        isStore;
		logic [1:0]  memSize;
		logic        memUnsigned;
		logic        regWr;
		logic        valid;
	} idExS;

	typedef struct packed {
		logic [31:0] result;   // alu value or effective address
		logic [31:0] storeData;
		logic [4:0]  rd;
		logic        isLoad;
		logic        isStore;
		logic [1:0]  memSize;
		logic        memUnsigned;
		logic        regWr;
		logic        valid;
	} exMemS;

	typedef struct packed {
		logic [31:0] result;
		logic [4:0]  rd;
		logic        regWr;
		logic        valid;
	} memWbS;

	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] value;
	} wbRecS;

endpackage

/* hw/instrQueue.sv */
`timescale 1ns/1ps

module instrQueue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic          clk,
	input  logic          arstN,
	input  dlxPkg::instrU inWord,
	input  logic          inValid,
	output logic          inReady,
	output dlxPkg::instrU outWord,
	output logic          outValid,
	input  logic          outReady
);
	import dlxPkg::*;

	localparam int PW = $clog2(QUEUE_DEPTH);
	localparam logic [PW:0] FULL_CNT = (PW + 1)'(QUEUE_DEPTH);

	instrU slots [QUEUE_DEPTH];
	logic [PW-1:0] wrPtr;
	logic [PW-1:0] rdPtr;
	logic [PW:0] count;
	logic push;
	logic pop;

	assign inReady = count != FULL_CNT;
	assign outValid = count != '0;
	assign outWord = slots[rdPtr];
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wrPtr] <= inWord;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;   // wraps, depth is a power of two
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	noOverflow: assert property (@(posedge clk) disable iff (!arstN) count <= FULL_CNT);
	noUnderflow: assert property (@(posedge clk) disable iff (!arstN)
		(count == '0) |=> (count <= 1));

endmodule

/* hw/pipelineControl.sv */
`timescale 1ns/1ps

module pipelineControl (
	input  logic           clk,
	input  logic           arstN,
	input  dlxPkg::instrU  inWord,
	input  logic           inValid,
	output logic           inReady,
	input  dlxPkg::exMemS  exStage,
	input  dlxPkg::memWbS  memStage,
	output logic [4:0]     rdAddr1,
	output logic [4:0]     rdAddr2,
	input  logic [31:0]    rdData1,
	input  logic [31:0]    rdData2,
	input  logic           advance,
	output dlxPkg::fwdSelE fwdA,
	output dlxPkg::fwdSelE fwdB,
	output dlxPkg::idExS   idEx
);
	import dlxPkg::*;

	instrU curWord;
	logic curValid;
	logic [5:0] op;
	idExS dec;
	idExS issue;
	logic rAlu;
	logic iAlu;
	logic usesRs1;
	logic usesRs2;
	logic loadUse;

	// operand source as seen one cycle later in execute
	function automatic fwdSelE fwdFor(input logic [4:0] src, input logic used);
		fwdSelE sel;
		sel = FWD_REG;
		if (used && src != 5'd0)
		begin
			if (idEx.valid && idEx.regWr && idEx.rd == src)
				sel = FWD_EXMEM;
			else if (exStage.valid && exStage.regWr && exStage.rd == src)
				sel = FWD_MEMWB;
		end
		return sel;
	endfunction

	assign op = curWord.r.opcode;
	assign rdAddr1 = curWord.r.rs1;
	assign rdAddr2 = curWord.r.rs2;   // same bits as the I view rd

	always_comb
	begin
		dec = '0;
		rAlu = 1'b0;
		iAlu = 1'b1;
		dec.aluOp = ALU_ADD;   // loads and stores add the offset
		if (op == OP_RTYPE)
		begin
			rAlu = 1'b1;
			case (curWord.r.func)
				FN_ADD, FN_ADDU: dec.aluOp = ALU_ADD;
				FN_SUB, FN_SUBU: dec.aluOp = ALU_SUB;
				FN_AND: dec.aluOp = ALU_AND;
				FN_OR: dec.aluOp = ALU_OR;
				FN_XOR: dec.aluOp = ALU_XOR;
				FN_SLL: dec.aluOp = ALU_SLL;
				FN_SRL: dec.aluOp = ALU_SRL;
				FN_SRA: dec.aluOp = ALU_SRA;
				FN_SEQ: dec.aluOp = ALU_SEQ;
				FN_SNE: dec.aluOp = ALU_SNE;
				FN_SLT: dec.aluOp = ALU_SLT;
				FN_SGT: dec.aluOp = ALU_SGT;
				FN_SLE: dec.aluOp = ALU_SLE;
				FN_SGE: dec.aluOp = ALU_SGE;
				default: rAlu = 1'b0;   // includes the nop word
			endcase
		end
		case (op)
			OP_ADDI, OP_ADDUI: dec.aluOp = ALU_ADD;
			OP_SUBI, OP_SUBUI: dec.aluOp = ALU_SUB;
			OP_ANDI: dec.aluOp = ALU_AND;
			OP_ORI: dec.aluOp = ALU_OR;
			OP_XORI: dec.aluOp = ALU_XOR;
			OP_LHI: dec.aluOp = ALU_LHI;
			OP_SLLI: dec.aluOp = ALU_SLL;
			OP_SRLI: dec.aluOp = ALU_SRL;
			OP_SRAI: dec.aluOp = ALU_SRA;
			OP_SEQI: dec.aluOp = ALU_SEQ;
			OP_SNEI: dec.aluOp = ALU_SNE;
			OP_SLTI: dec.aluOp = ALU_SLT;
			OP_SGTI: dec.aluOp = ALU_SGT;
			OP_SLEI: dec.aluOp = ALU_SLE;
			OP_SGEI: dec.aluOp = ALU_SGE;
			default: iAlu = 1'b0;
		endcase
		dec.isLoad = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		dec.isStore = op inside {OP_SB, OP_SH, OP_SW};
		dec.memUnsigned = op inside {OP_LBU, OP_LHU};
		if (op inside {OP_LB, OP_LBU, OP_SB})
			dec.memSize = MSZ_BYTE;
		else if (op inside {OP_LH, OP_LHU, OP_SH})
			dec.memSize = MSZ_HALF;
		else
			dec.memSize = MSZ_WORD;
		if (op inside {OP_ADDUI, OP_SUBUI, OP_ANDI, OP_ORI, OP_XORI})
			dec.imm = {16'h0000, curWord.i.imm16};
		else
			dec.imm = {{16{curWord.i.imm16[15]}}, curWord.i.imm16};
		dec.rs1 = curWord.r.rs1;
		dec.rs2 = curWord.r.rs2;
		dec.rd = rAlu ? curWord.r.rd : curWord.i.rd;
		dec.useImm = !rAlu;
		dec.regWr = rAlu || iAlu || dec.isLoad;
		usesRs1 = rAlu || (iAlu && op != OP_LHI) || dec.isLoad || dec.isStore;
		usesRs2 = rAlu || dec.isStore;
	end

	// load in execute feeds this word, hold it one cycle
	assign loadUse = curValid && idEx.valid && idEx.isLoad && idEx.rd != 5'd0 &&
		((usesRs1 && dec.rs1 == idEx.rd) || (usesRs2 && dec.rs2 == idEx.rd));
	assign inReady = advance && !loadUse;

	always_comb
	begin
		issue = dec;
		issue.rs1Val = rdData1;
		issue.rs2Val = rdData2;
		issue.valid = curValid && !loadUse;
		issue.regWr = dec.regWr && issue.valid;
		issue.isLoad = dec.isLoad && issue.valid;
		issue.isStore = dec.isStore && issue.valid;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			curWord <= NOP_WORD;
			curValid <= 1'b0;
			idEx <= '0;
			fwdA <= FWD_REG;
			fwdB <= FWD_REG;
		end
		else if (advance)
		begin
			if (!loadUse)
			begin
				curWord <= inWord;
				curValid <= inValid;
			end
			idEx <= issue;
			fwdA <= fwdFor(dec.rs1, usesRs1);
			fwdB <= fwdFor(dec.rs2, usesRs2);
		end
	end

	// a load address must never reach execute as forwarded data
	loadNotForwarded: assert property (@(posedge clk) disable iff (!arstN)
		(idEx.valid && exStage.valid && exStage.isLoad) |->
		(fwdA != FWD_EXMEM && fwdB != FWD_EXMEM));
	// a memwb selection must find its producer in writeback
	fwdMatchesWb: assert property (@(posedge clk) disable iff (!arstN)
		(idEx.valid && fwdA == FWD_MEMWB) |->
		(memStage.valid && memStage.regWr && memStage.rd == idEx.rs1));
	fwdBMatchesWb: assert property (@(posedge clk) disable iff (!arstN)
		(idEx.valid && fwdB == FWD_MEMWB) |->
		(memStage.valid && memStage.regWr && memStage.rd == idEx.rs2));

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rdAddr1,
	input  logic [4:0]  rdAddr2,
	output logic [31:0] rdData1,
	output logic [31:0] rdData2,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData
);
	logic [31:0] regs [32];

	// writeback in the same cycle is seen by decode
	assign rdData1 = (rdAddr1 == 5'd0) ? 32'h0 :
		(wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
	assign rdData2 = (rdAddr2 == 5'd0) ? 32'h0 :
		(wrEn && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end
		else if (wrEn && wrAddr != 5'd0)
			regs[wrAddr] <= wrData;
	end

endmodule

/* hw/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
	input  logic           clk,
	input  logic           arstN,
	input  dlxPkg::idExS   idEx,
	input  dlxPkg::fwdSelE fwdA,
	input  dlxPkg::fwdSelE fwdB,
	input  logic [31:0]    wbResult,
	input  logic           advance,
	output dlxPkg::exMemS  exMem
);
	import dlxPkg::*;

	logic [31:0] opA;
	logic [31:0] regB;
	logic [31:0] opB;
	logic [4:0] shAmt;
	logic [31:0] aluOut;

	always_comb
	begin
		case (fwdA)
			FWD_EXMEM: opA = exMem.result;
			FWD_MEMWB: opA = wbResult;
			default: opA = idEx.rs1Val;
		endcase
		case (fwdB)
			FWD_EXMEM: regB = exMem.result;
			FWD_MEMWB: regB = wbResult;
			default: regB = idEx.rs2Val;
		endcase
	end

	assign opB = idEx.useImm ? idEx.imm : regB;
	assign shAmt = opB[4:0];

	always_comb
	begin
		case (idEx.aluOp)
			ALU_ADD: aluOut = opA + opB;   // also the load/store address
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_XOR: aluOut = opA ^ opB;
			ALU_SLL: aluOut = opA << shAmt;
			ALU_SRL: aluOut = opA >> shAmt;
			ALU_SRA: aluOut = $unsigned($signed(opA) >>> shAmt);
			ALU_SEQ: aluOut = {31'h0, opA == opB};
			ALU_SNE: aluOut = {31'h0, opA != opB};
			ALU_SLT: aluOut = {31'h0, $signed(opA) < $signed(opB)};
			ALU_SGT: aluOut = {31'h0, $signed(opA) > $signed(opB)};
			ALU_SLE: aluOut = {31'h0, $signed(opA) <= $signed(opB)};
			ALU_SGE: aluOut = {31'h0, $signed(opA) >= $signed(opB)};
			ALU_LHI: aluOut = {idEx.imm[15:0], 16'h0000};
			default: aluOut = 32'h0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			exMem <= '0;
		else if (advance)
		begin
			exMem <= '{
				result: aluOut,
				storeData: regB,   // store data register, forwarded
				rd: idEx.rd,
				isLoad: idEx.isLoad,
				isStore: idEx.isStore,
				memSize: idEx.memSize,
				memUnsigned: idEx.memUnsigned,
				regWr: idEx.regWr,
				valid: idEx.valid
			};
		end
	end

endmodule

/* hw/memStage.sv */
`timescale 1ns/1ps

module memStage #(
	parameter int DMEM_WORDS = 256
) (
	input  logic          clk,
	input  logic          arstN,
	input  dlxPkg::exMemS exMem,
	input  logic          advance,
	output dlxPkg::memWbS memWb
);
	import dlxPkg::*;

	localparam int AW = $clog2(DMEM_WORDS);

	logic [31:0] mem [DMEM_WORDS];
	logic [AW-1:0] wordIdx;
	logic [1:0] lane;
	logic [3:0] byteEn;
	logic [31:0] wrWord;
	logic [31:0] laneVal;
	logic [31:0] loadVal;

	assign wordIdx = exMem.result[AW+1:2];
	assign lane = exMem.result[1:0];
	assign laneVal = mem[wordIdx] >> {lane, 3'b000};   // byte 0 sits in bits 7:0

	always_comb
	begin
		case (exMem.memSize)
			MSZ_BYTE:
			begin
				byteEn = 4'b0001 << lane;
				wrWord = {4{exMem.storeData[7:0]}};
				loadVal = exMem.memUnsigned ? {24'h0, laneVal[7:0]} :
					{{24{laneVal[7]}}, laneVal[7:0]};
			end
			MSZ_HALF:
			begin
				byteEn = 4'b0011 << {lane[1], 1'b0};
				wrWord = {2{exMem.storeData[15:0]}};
				loadVal = exMem.memUnsigned ? {16'h0, laneVal[15:0]} :
					{{16{laneVal[15]}}, laneVal[15:0]};
			end
			default:
			begin
				byteEn = 4'b1111;
				wrWord = exMem.storeData;
				loadVal = laneVal;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (advance && exMem.valid && exMem.isStore)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (byteEn[b])
					mem[wordIdx][8*b +: 8] <= wrWord[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			memWb <= '0;
		else if (advance)
		begin
			memWb.result <= exMem.isLoad ? loadVal : exMem.result;
			memWb.rd <= exMem.rd;
			memWb.regWr <= exMem.regWr;
			memWb.valid <= exMem.valid;
		end
	end

	aligned: assert property (@(posedge clk) disable iff (!arstN)
		(exMem.valid && (exMem.isLoad || exMem.isStore) && exMem.memSize != MSZ_BYTE) |->
		(!exMem.result[0] && (exMem.memSize == MSZ_HALF || !exMem.result[1])));

endmodule

/* hw/writebackPort.sv */
`timescale 1ns/1ps

module writebackPort (
	input  logic          clk,
	input  logic          arstN,
	input  dlxPkg::memWbS memWb,
	output logic          wrEn,
	output logic [4:0]    wrAddr,
	output logic [31:0]   wrData,
	output dlxPkg::wbRecS rec,
	output logic          recValid,
	input  logic          recReady,
	output logic          advance
);
	logic commit;

	assign commit = memWb.valid && memWb.regWr && memWb.rd != 5'd0;
	// freeze only when a held record would be overwritten
	assign advance = !(recValid && !recReady && commit);
	assign wrEn = commit && advance;
	assign wrAddr = memWb.rd;
	assign wrData = memWb.result;

	always_ff @(posedge clk)
	begin
		if (wrEn)
			rec <= '{rd: memWb.rd, value: memWb.result};
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			recValid <= 1'b0;
		else if (wrEn)
			recValid <= 1'b1;
		else if (recReady)
			recValid <= 1'b0;
	end

	recHeld: assert property (@(posedge clk) disable iff (!arstN)
		(recValid && !recReady) |=> (recValid && $stable(rec)));

endmodule

/* hw/dlxCore.sv */
`timescale 1ns/1ps

module dlxCore #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DMEM_WORDS = 256
) (
	input  logic          clk,
	input  logic          arstN,
	input  dlxPkg::instrU instr,
	input  logic          instrValid,
	output logic          instrReady,
	output dlxPkg::wbRecS rec,
	output logic          recValid,
	input  logic          recReady
);
	import dlxPkg::*;

	instrU qWord;
	logic qValid;
	logic qReady;
	logic [4:0] rdAddr1;
	logic [4:0] rdAddr2;
	logic [31:0] rdData1;
	logic [31:0] rdData2;
	fwdSelE fwdA;
	fwdSelE fwdB;
	idExS idEx;
	exMemS exMem;
	memWbS memWb;
	logic wrEn;
	logic [4:0] wrAddr;
	logic [31:0] wrData;
	logic advance;

	instrQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk, .arstN,
		.inWord(instr), .inValid(instrValid), .inReady(instrReady),
		.outWord(qWord), .outValid(qValid), .outReady(qReady)
	);

	pipelineControl u_ctrl (
		.clk, .arstN,
		.inWord(qWord), .inValid(qValid), .inReady(qReady),
		.exStage(exMem), .memStage(memWb),
		.rdAddr1, .rdAddr2, .rdData1, .rdData2,
		.advance, .fwdA, .fwdB, .idEx
	);

	regFile u_regs (
		.clk, .arstN,
		.rdAddr1, .rdAddr2, .rdData1, .rdData2,
		.wrEn, .wrAddr, .wrData
	);

	execUnit u_exec (
		.clk, .arstN,
		.idEx, .fwdA, .fwdB,
		.wbResult(memWb.result), .advance, .exMem
	);

	memStage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
		.clk, .arstN,
		.exMem, .advance, .memWb
	);

	writebackPort u_wb (
		.clk, .arstN, .memWb,
		.wrEn, .wrAddr, .wrData,
		.rec, .recValid, .recReady, .advance
	);

endmodule

/* verification/dlxCoreTb.sv */
`timescale 1ns/1ps

module dlxCoreTb;
	import dlxPkg::*;

	localparam logic [15:0] LFSR_SEED = 16'd18034;

	logic clk;
	logic arstN;
	instrU instr;
	logic instrValid;
	logic instrReady;
	wbRecS rec;
	logic recValid;
	logic recReady;

	logic [31:0] words [$];
	logic [4:0] expRd [$];
	logic [31:0] expVal [$];
	logic [127:0] expName [$];
	logic [15:0] gapLfsr;
	logic [15:0] readyLfsr;
	logic [1:0] readyBits;
	logic running;
	int cycles;
	int cycleLimit;
	int recCount;

	dlxCore #(.QUEUE_DEPTH(4), .DMEM_WORDS(256)) u_dut (
		.clk, .arstN, .instr, .instrValid, .instrReady, .rec, .recValid, .recReady
	);

	always #10 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic takeTwoBits(inout logic [15:0] state, output logic [1:0] bits);
		state = lfsrStep(state);
		bits[0] = state[0];
		state = lfsrStep(state);
		bits[1] = state[0];
	endtask

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic checkEq(input logic [127:0] testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("ERR %0s %0s expected %h actual %h",
				testName, what, expected, actual));
	endtask

	task automatic loadTests();
		int fd;
		int n;
		int ch;
		logic [7:0] tag;
		logic [127:0] curName;
		logic [31:0] word;
		logic [4:0] rd;
		logic [31:0] value;
		curName = "none";
		fd = $fopen("verification/dlxTests.txt", "r");
		if (fd == 0)
			failRun("could not open verification/dlxTests.txt");
		while ($fscanf(fd, " %c", tag) == 1)
		begin
			n = 1;
			case (tag)
				"#":
				begin
					ch = $fgetc(fd);   // rest of line is a note
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end
				"T": n = $fscanf(fd, "%s", curName);
				"I":
				begin
					n = $fscanf(fd, "%h", word);
					words.push_back(word);
				end
				"E":
				begin
					if ($fscanf(fd, "%d %h", rd, value) != 2)
						n = 0;
					expRd.push_back(rd);
					expVal.push_back(value);
					expName.push_back(curName);
				end
				default: n = 0;
			endcase
			if (n != 1)
				failRun($sformatf("test file is malformed near tag '%c'", tag));
		end
		$fclose(fd);
	endtask

	task automatic driveWords();
		int idx;
		logic [1:0] bits;
		idx = 0;
		while (idx < words.size())
		begin
			@(posedge clk);
			takeTwoBits(gapLfsr, bits);
			if (bits == 2'b00)
				instrValid <= 1'b0;   // idle cycle
			else
			begin
				instr <= words[idx];
				instrValid <= 1'b1;
				@(negedge clk);
				while (!instrReady)
					@(negedge clk);
				idx++;   // taken on the coming edge
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	always @(posedge clk)
	begin
		if (running)
		begin
			takeTwoBits(readyLfsr, readyBits);
			recReady <= |readyBits;   // low one cycle in four
		end
	end

	always @(posedge clk)
	begin
		if (running)
		begin
			cycles = cycles + 1;
			if (cycles > cycleLimit)
				failRun($sformatf("timeout after %0d cycles with %0d records still expected",
					cycles, expRd.size()));
		end
	end

	// a record moves on the next rising edge
	always @(negedge clk)
	begin
		if (running && recValid && recReady)
		begin
			if (expRd.size() == 0)
				failRun($sformatf("unexpected record for r%0d with value %h",
					rec.rd, rec.value));
			else
			begin
				checkEq(expName[0], "rd", {27'd0, expRd[0]}, {27'd0, rec.rd});
				checkEq(expName[0], "value", expVal[0], rec.value);
				expRd.delete(0);
				expVal.delete(0);
				expName.delete(0);
				recCount++;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		instr = NOP_WORD;
		instrValid = 1'b0;
		recReady = 1'b0;
		gapLfsr = LFSR_SEED;
		readyLfsr = LFSR_SEED;
		running = 1'b0;
		cycles = 0;
		recCount = 0;
		loadTests();
		cycleLimit = 8 * words.size() + 200;
		repeat (10)
		begin
			@(negedge clk);
			checkEq("reset", "recValid", 32'd0, {31'd0, recValid});
			checkEq("reset", "instrReady", 32'd1, {31'd0, instrReady});
		end
		@(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkEq("reset", "recValid", 32'd0, {31'd0, recValid});
		checkEq("reset", "instrReady", 32'd1, {31'd0, instrReady});
		running = 1'b1;
		driveWords();
		while (expRd.size() != 0)
			@(negedge clk);
		repeat (10)
			@(negedge clk);   // stray records would show here
		if (recValid)
			failRun($sformatf("an extra record for r%0d is still waiting at the end", rec.rd));
		else
		begin
			$display("%0d records matched", recCount);
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* verification/dlxTests.txt */
# T name starts a test, I word is one instruction in hex
# E rd value is the next expected writeback record, rd in decimal and value in hex
T rchain
I 20010005 E 1 00000005  I 2002FFFD E 2 FFFFFFFD  # addi r1,r0,5  addi r2,r0,-3
I 00221820 E 3 00000002  I 00612022 E 4 FFFFFFFD  # add r3,r1,r2  sub r4,r3,r1
I 00832825 E 5 FFFFFFFF  I 00A13026 E 6 FFFFFFFA  # or r5,r4,r3  xor r6,r5,r1
I 00233804 E 7 00000014  I 00C34007 E 8 FFFFFFFE  # sll r7,r1,r3  sra r8,r6,r3
I 01014806 E 9 07FFFFFF  I 0041502A E 10 00000001  # srl r9,r8,r1  slt r10,r2,r1
I 0041582B E 11 00000000  I 0129602C E 12 00000001  # sgt r11,r2,r1  sle r12,r9,r9
I 004A682D E 13 00000000  I 00827028 E 14 00000001  # sge r13,r2,r10  seq r14,r4,r2
I 01CC7829 E 15 00000000  I 00278023 E 16 FFFFFFF1  # sne r15,r14,r12  subu r16,r1,r7
I 02108821 E 17 FFFFFFE2  # addu r17,r16,r16
T itype
I 3C121234 E 18 12340000  I 36528001 E 18 12348001  # lhi r18,0x1234  ori r18,r18,0x8001
I 22538000 E 19 12340001  I 24148000 E 20 00008000  # addi r19,r18,-0x8000  addui r20,r0,0x8000
I 3275FF0F E 21 00000001  I 3856FFFF E 22 FFFF0002  # andi r21,r19,0xff0f  xori r22,r2,0xffff
I 2AD7FFFE E 23 FFFF0004  I 2C180001 E 24 FFFFFFFF  # subi r23,r22,-2  subui r24,r0,1
I 50390004 E 25 00000050  I 5E1A0002 E 26 FFFFFFFC  # slli r25,r1,4  srai r26,r16,2
I 5A1B001C E 27 0000000F  I 603C0005 E 28 00000001  # srli r27,r16,28  seqi r28,r1,5
I 643D0005 E 29 00000000  I 685EFFFE E 30 00000001  # snei r29,r1,5  slti r30,r2,-2
I 6C5FFFFC E 31 00000001  I 729C7FFF E 28 00000000  # sgti r31,r2,-4  slei r28,r20,0x7fff
I 749D8000 E 29 00000001  # sgei r29,r20,-0x8000
T mem
I AC120040  I 80010041 E 1 FFFFFF80  # sw r18,0x40(r0)  lb r1,0x41(r0)
I 90020041 E 2 00000080  I 84030040 E 3 FFFF8001  # lbu r2,0x41(r0)  lh r3,0x40(r0)
I 94040040 E 4 00008001  I 8C050040 E 5 12348001  # lhu r4,0x40(r0)  lw r5,0x40(r0)
I 00A53020 E 6 24690002  # add r6,r5,r5 right after the load
I A4020042  I A0010043  # sh r2,0x42(r0)  sb r1,0x43(r0)
I 8C070040 E 7 80808001  I 84080042 E 8 FFFF8080  # lw r7,0x40(r0)  lh r8,0x42(r0)
I 21090001 E 9 FFFF8081  # addi r9,r8,1 right after the load
I 8C0A0040 E 10 80808001  I AC0A0048  # lw r10,0x40(r0)  sw r10,0x48(r0)
I 8C0B0048 E 11 80808001  # lw r11,0x48(r0)
T zero
I 00000015  I 20200007  # nop  addi r0,r1,7
I 00006020 E 12 00000000  I 8C000040  # add r12,r0,r0  lw r0,0x40(r0)
I 00016825 E 13 FFFFFF80  I FC2100FF  # or r13,r0,r1  unused opcode 0x3f
T stream
I 21CE0003 E 14 00000004  I 21CE0003 E 14 00000007  # addi r14,r14,3 twice
I 21CE0003 E 14 0000000A  I 21CE0003 E 14 0000000D  # two more of the same

/* sim.f */
hw/dlxPkg.sv
hw/instrQueue.sv
hw/pipelineControl.sv
hw/regFile.sv
hw/execUnit.sv
hw/memStage.sv
hw/writebackPort.sv
hw/dlxCore.sv
verification/dlxCoreTb.sv
